// ==== common/sprite_pkg.sv ====
package sprite_pkg;

    typedef logic [8:0]  line_idx_t;
    typedef logic [9:0]  xpos_t;
    typedef logic [14:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;
    typedef logic [31:0] attr_word_t;
    typedef logic [6:0]  sprite_num_t;
    typedef logic [5:0]  sprite_row_t;
    typedef logic [7:0]  pixel_t;
    typedef logic [1:0]  zdepth_t;
    typedef logic [1:0]  size_code_t;

    // Upper bits hold z, lower bits hold the colour
    typedef logic [9:0]  linebuf_entry_t;

    // Low attribute half
    localparam int LO_ADDR_LSB   = 0;
    localparam int LO_MODE_BIT   = 15;
    localparam int LO_X_LSB      = 16;

    // High attribute half, bits 23:20 unused
    localparam int HI_Y_LSB      = 0;
    localparam int HI_HFLIP_BIT  = 16;
    localparam int HI_VFLIP_BIT  = 17;
    localparam int HI_Z_LSB      = 18;
    localparam int HI_PAL_LSB    = 24;
    localparam int HI_WIDTH_LSB  = 28;
    localparam int HI_HEIGHT_LSB = 30;

    typedef enum logic [1:0] {SF_FIND, SF_START_RENDER, SF_DONE} search_state_t;

    typedef enum logic [1:0] {R_IDLE, R_WAIT_FETCH, R_RENDER, R_DONE} render_state_t;

    // Last pixel index for a size code: 7, 15, 31 or 63
    function automatic logic [5:0] size_last(size_code_t code);
        logic [6:0] pixels;
        pixels = 7'd8 << code;
        return 6'(pixels - 7'd1);
    endfunction

endpackage

// ==== common/render_job_if.sv ====
interface render_job_if import sprite_pkg::*; ();

    logic        start;
    logic [11:0] gfx_addr;
    logic        mode;
    xpos_t       x;
    sprite_row_t row;
    logic        hflip;
    zdepth_t     z;
    logic [3:0]  palette;
    size_code_t  width;
    logic        budget_out;
    logic        busy;

    modport search (
        output start, gfx_addr, mode, x, row, hflip, z, palette, width, budget_out,
        input  busy
    );

    modport renderer (
        input  start, gfx_addr, mode, x, row, hflip, z, palette, width, budget_out,
        output busy
    );

endinterface

// ==== rtl/sprite_search.sv ====
module sprite_search import sprite_pkg::*; #(
    parameter int RENDER_CYCLES = 798
) (
    input  logic         clk,
    input  logic         rst,
    input  line_idx_t    line_idx,
    input  logic         line_render_start,
    output logic [7:0]   sprite_idx,
    input  attr_word_t   sprite_attr,
    render_job_if.search job
);

    localparam int BW = $clog2(RENDER_CYCLES + 1);

    //////////////////////////////////////////////////
    // Render time budget
    //////////////////////////////////////////////////
    logic [BW-1:0] budget_cnt;
    logic          budget_done;

    assign budget_done    = (budget_cnt == BW'(RENDER_CYCLES));
    assign job.budget_out = budget_done;

    // Starts expired so nothing runs before the first line
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            budget_cnt <= BW'(RENDER_CYCLES);
        end else if (line_render_start) begin
            budget_cnt <= '0;
        end else if (!budget_done) begin
            budget_cnt <= budget_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // High half decode
    //////////////////////////////////////////////////
    logic [9:0]  attr_y;
    logic [5:0]  height_last;
    logic [9:0]  ydiff;
    logic        on_line;
    logic        enabled;
    sprite_row_t row;

    assign attr_y      = sprite_attr[HI_Y_LSB +: 10];
    assign height_last = size_last(sprite_attr[HI_HEIGHT_LSB +: $bits(size_code_t)]);
    assign ydiff       = {1'b0, line_idx} - attr_y;
    assign on_line     = (ydiff <= {4'b0, height_last});
    assign enabled     = (sprite_attr[HI_Z_LSB +: $bits(zdepth_t)] != '0);
    assign row         = sprite_attr[HI_VFLIP_BIT] ? (height_last - ydiff[5:0]) : ydiff[5:0];

    //////////////////////////////////////////////////
    // Scan FSM
    //////////////////////////////////////////////////
    search_state_t state, state_next;
    sprite_num_t   idx, idx_next;
    logic          start_next;
    logic          save_hi;
    logic          save_lo;
    logic          hi_sel;

    // High half while searching, low half in the start cycle
    assign hi_sel     = (state != SF_START_RENDER);
    assign sprite_idx = {idx, hi_sel};

    always_comb begin
        state_next = state;
        idx_next   = idx;
        start_next = 1'b0;
        save_hi    = 1'b0;
        save_lo    = 1'b0;

        case (state)
            SF_FIND: begin
                if (enabled && on_line) begin
                    // Wait until the renderer has taken the previous job
                    if (!job.busy && !job.start) begin
                        save_hi    = 1'b1;
                        state_next = SF_START_RENDER;
                    end
                end else if (idx == '1) begin
                    state_next = SF_DONE;
                end else begin
                    idx_next = idx + 1'b1;
                end
            end
            SF_START_RENDER: begin
                save_lo    = 1'b1;
                start_next = 1'b1;
                if (idx == '1) begin
                    state_next = SF_DONE;
                end else begin
                    idx_next   = idx + 1'b1;
                    state_next = SF_FIND;
                end
            end
            default: begin
            end
        endcase

        if (line_render_start) begin
            state_next = SF_FIND;
            idx_next   = '0;
            start_next = 1'b0;
        end else if (budget_done) begin
            state_next = SF_DONE;
            start_next = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= SF_DONE;
            idx       <= '0;
            job.start <= 1'b0;
        end else begin
            state     <= state_next;
            idx       <= idx_next;
            job.start <= start_next;
        end
    end

    // Job fields, held steady while the renderer works
    always_ff @(posedge clk) begin
        if (save_hi) begin
            job.row     <= row;
            job.hflip   <= sprite_attr[HI_HFLIP_BIT];
            job.z       <= sprite_attr[HI_Z_LSB +: $bits(zdepth_t)];
            job.palette <= sprite_attr[HI_PAL_LSB +: 4];
            job.width   <= sprite_attr[HI_WIDTH_LSB +: $bits(size_code_t)];
        end
        if (save_lo) begin
            job.gfx_addr <= sprite_attr[LO_ADDR_LSB +: 12];
            job.mode     <= sprite_attr[LO_MODE_BIT];
            job.x        <= sprite_attr[LO_X_LSB +: $bits(xpos_t)];
        end
    end

endmodule

// ==== line_render/line_renderer.sv ====
module line_renderer import sprite_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  logic           line_render_start,
    render_job_if.renderer job,
    output bus_addr_t      bus_addr,
    output logic           bus_strobe,
    input  logic           bus_ack,
    input  bus_data_t      bus_rddata,
    output xpos_t          linebuf_rdidx,
    output xpos_t          linebuf_wridx,
    output logic           linebuf_wren,
    output logic [2:0]     pixel_pos,
    output bus_data_t      fetch_word,
    input  logic           merge_write
);

    render_state_t state, state_next;
    logic [5:0]    xcnt, xcnt_next;
    bus_addr_t     addr_next;
    logic          strobe_next;
    bus_data_t     data_next;
    xpos_t         lb_idx, lb_idx_next;

    //////////////////////////////////////////////////
    // Fetch address
    //////////////////////////////////////////////////
    logic [5:0] width_last;
    logic [5:0] fetch_x;
    logic [5:0] fetch_hx;
    logic [2:0] wpr_log2;
    bus_addr_t  word_idx;
    bus_addr_t  fetch_addr;
    logic       word_end;

    assign width_last = size_last(job.width);

    // First word on start, following word on a refetch
    assign fetch_x  = (state == R_RENDER) ? xcnt + 6'd1 : 6'd0;
    assign fetch_hx = job.hflip ? ~fetch_x : fetch_x;

    // Words per row: width/8 in 4 bpp, width/4 in 8 bpp
    assign wpr_log2   = {1'b0, job.width} + {2'b0, job.mode};
    assign word_idx   = bus_addr_t'(fetch_hx >> (job.mode ? 2 : 3))
                      & ((bus_addr_t'(1) << wpr_log2) - bus_addr_t'(1));
    assign fetch_addr = {job.gfx_addr, 3'b000} + (bus_addr_t'(job.row) << wpr_log2) + word_idx;

    assign word_end = job.mode ? (xcnt[1:0] == 2'd3) : (xcnt[2:0] == 3'd7);

    //////////////////////////////////////////////////
    // Fetch and render FSM
    //////////////////////////////////////////////////
    always_comb begin
        state_next  = state;
        xcnt_next   = xcnt;
        addr_next   = bus_addr;
        strobe_next = bus_strobe;
        data_next   = fetch_word;
        lb_idx_next = lb_idx;

        case (state)
            R_IDLE: begin
                if (job.start) begin
                    lb_idx_next = job.x;
                    addr_next   = fetch_addr;
                    strobe_next = 1'b1;
                    state_next  = R_WAIT_FETCH;
                end
            end
            R_WAIT_FETCH: begin
                if (bus_ack) begin
                    strobe_next = 1'b0;
                    data_next   = bus_rddata;
                    state_next  = R_RENDER;
                end
            end
            R_RENDER: begin
                xcnt_next   = xcnt + 6'd1;
                lb_idx_next = lb_idx + 1'b1;
                if (word_end) begin
                    if (xcnt == width_last) begin
                        xcnt_next  = '0;
                        state_next = R_IDLE;
                    end else begin
                        addr_next   = fetch_addr;
                        strobe_next = 1'b1;
                        state_next  = R_WAIT_FETCH;
                    end
                end
            end
            default: begin
                strobe_next = 1'b0;
            end
        endcase

        if (line_render_start) begin
            state_next  = R_IDLE;
            xcnt_next   = '0;
            strobe_next = 1'b0;
        end else if (job.budget_out) begin
            state_next  = R_DONE;
            strobe_next = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= R_IDLE;
            xcnt       <= '0;
            bus_strobe <= 1'b0;
            bus_addr   <= '0;
            lb_idx     <= '0;
        end else begin
            state      <= state_next;
            xcnt       <= xcnt_next;
            bus_strobe <= strobe_next;
            bus_addr   <= addr_next;
            lb_idx     <= lb_idx_next;
        end
    end

    always_ff @(posedge clk) begin
        fetch_word <= data_next;
    end

    // Read one entry ahead, write back the current one
    assign linebuf_rdidx = lb_idx_next;
    assign linebuf_wridx = lb_idx;
    assign linebuf_wren  = (state == R_RENDER) && merge_write && !job.budget_out;

    assign pixel_pos = job.hflip ? ~xcnt[2:0] : xcnt[2:0];
    assign job.busy  = (state != R_IDLE);

endmodule

// ==== line_render/pixel_merge.sv ====
module pixel_merge import sprite_pkg::*; (
    input  logic [2:0]     pixel_pos,
    input  logic           mode,
    input  logic [3:0]     palette,
    input  zdepth_t        z,
    input  bus_data_t      word,
    input  linebuf_entry_t dest,
    output linebuf_entry_t entry,
    output logic           write
);

    localparam int CW = $bits(pixel_t);

    logic [7:0] byte_4bpp;
    pixel_t     raw;
    pixel_t     colour;
    logic       transparent;
    logic       dest_clear;
    zdepth_t    dest_z;

    // 4 bpp shares the byte lanes, high nibble first
    assign byte_4bpp = word[{pixel_pos[2:1], 3'b000} +: 8];

    always_comb begin
        if (mode) begin
            raw = word[{pixel_pos[1:0], 3'b000} +: 8];
        end else begin
            raw = {4'b0, (pixel_pos[0] ? byte_4bpp[3:0] : byte_4bpp[7:4])};
        end
    end

    assign transparent = (raw == '0);

    // Palette offset only fills an empty upper nibble
    assign colour = (raw[7:4] == 4'b0 && !transparent) ? {palette, raw[3:0]} : raw;

    assign entry = {z, colour};

    //////////////////////////////////////////////////
    // Z priority against the destination
    //////////////////////////////////////////////////
    assign dest_z     = dest[CW +: $bits(zdepth_t)];
    assign dest_clear = (dest[CW-1:0] == '0);
    assign write      = !transparent && ((z > dest_z) || dest_clear);

endmodule

// ==== rtl/sprite_renderer.sv ====
module sprite_renderer import sprite_pkg::*; #(
    parameter int RENDER_CYCLES = 798
) (
    input  logic           clk,
    input  logic           rst,

    // Line timing
    input  line_idx_t      line_idx,
    input  logic           line_render_start,

    // Graphics fetch bus
    output bus_addr_t      bus_addr,
    input  bus_data_t      bus_rddata,
    output logic           bus_strobe,
    input  logic           bus_ack,

    // Attribute RAM
    output logic [7:0]     sprite_idx,
    input  attr_word_t     sprite_attr,

    // Line buffer
    output xpos_t          linebuf_rdidx,
    input  linebuf_entry_t linebuf_rddata,
    output xpos_t          linebuf_wridx,
    output linebuf_entry_t linebuf_wrdata,
    output logic           linebuf_wren
);

    render_job_if job ();

    logic [2:0] pixel_pos;
    bus_data_t  fetch_word;
    logic       merge_write;

    sprite_search #(
        .RENDER_CYCLES (RENDER_CYCLES)
    ) u_search (
        .clk               (clk),
        .rst               (rst),
        .line_idx          (line_idx),
        .line_render_start (line_render_start),
        .sprite_idx        (sprite_idx),
        .sprite_attr       (sprite_attr),
        .job               (job.search)
    );

    line_renderer u_renderer (
        .clk               (clk),
        .rst               (rst),
        .line_render_start (line_render_start),
        .job               (job.renderer),
        .bus_addr          (bus_addr),
        .bus_strobe        (bus_strobe),
        .bus_ack           (bus_ack),
        .bus_rddata        (bus_rddata),
        .linebuf_rdidx     (linebuf_rdidx),
        .linebuf_wridx     (linebuf_wridx),
        .linebuf_wren      (linebuf_wren),
        .pixel_pos         (pixel_pos),
        .fetch_word        (fetch_word),
        .merge_write       (merge_write)
    );

    // Merge decision, gated by the renderer state
    pixel_merge u_merge (
        .pixel_pos (pixel_pos),
        .mode      (job.mode),
        .palette   (job.palette),
        .z         (job.z),
        .word      (fetch_word),
        .dest      (linebuf_rddata),
        .entry     (linebuf_wrdata),
        .write     (merge_write)
    );

endmodule

// ==== tb/sprite_renderer_checker.sv ====
module sprite_renderer_checker import sprite_pkg::*; #(
    parameter int RENDER_CYCLES = 798
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      line_render_start,
    input  logic      bus_strobe,
    input  logic      bus_ack,
    input  bus_addr_t bus_addr,
    input  logic      linebuf_wren
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned since_start;
    logic        live;

    // Cycles since the last line start, saturating at the budget
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            since_start <= RENDER_CYCLES;
        end else if (line_render_start) begin
            since_start <= 0;
        end else if (since_start < RENDER_CYCLES) begin
            since_start <= since_start + 1;
        end
    end

    // A line start or an expired budget may cut a fetch short
    assign live = !line_render_start && (since_start < RENDER_CYCLES);

    strobe_held: assert property (@(posedge clk) disable iff (rst)
        bus_strobe && !bus_ack && live |=> bus_strobe)
        else $error("bus_strobe dropped before bus_ack");

    addr_stable: assert property (@(posedge clk) disable iff (rst)
        bus_strobe && !bus_ack && live |=> $stable(bus_addr))
        else $error("bus_addr changed while the fetch was pending");

    wren_in_budget: assert property (@(posedge clk) disable iff (rst)
        linebuf_wren |-> since_start < RENDER_CYCLES)
        else $error("linebuf_wren high after the render budget expired");

endmodule

bind sprite_renderer sprite_renderer_checker #(
    .RENDER_CYCLES (RENDER_CYCLES)
) u_checker (
    .clk               (clk),
    .rst               (rst),
    .line_render_start (line_render_start),
    .bus_strobe        (bus_strobe),
    .bus_ack           (bus_ack),
    .bus_addr          (bus_addr),
    .linebuf_wren      (linebuf_wren)
);

// ==== tb/tb_sprite_renderer.sv ====
module tb_sprite_renderer import sprite_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RENDER_CYCLES = 798;
    localparam int NUM_LINES     = 7;
    localparam int LIMIT         = NUM_LINES * (RENDER_CYCLES + 10) + 100;

    logic clk, rst, line_render_start, bus_strobe, bus_ack, linebuf_wren;
    line_idx_t line_idx;
    bus_addr_t bus_addr;
    bus_data_t bus_rddata;
    logic [7:0] sprite_idx;
    attr_word_t sprite_attr;
    xpos_t linebuf_rdidx, linebuf_wridx;
    linebuf_entry_t linebuf_rddata, linebuf_wrdata;

    attr_word_t attr_lo [128];
    attr_word_t attr_hi [128];
    linebuf_entry_t lb_mem [1024];
    linebuf_entry_t exp_buf [1024];
    logic [15:0] lfsr;
    logic [1:0] wait_cnt;
    int unsigned since_start;
    int unsigned cycles;
    logic compare_pending;

    sprite_renderer #(.RENDER_CYCLES(RENDER_CYCLES)) DUT (.*);

    always #10 clk = ~clk;

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // Graphics word from the address with transparent and short bytes
    function automatic bus_data_t gfx_word(input bus_addr_t addr);
        bus_data_t w;
        logic [7:0] b;
        w = (32'(addr) * 32'h2545_F491) ^ {addr, 17'h0};
        for (int i = 0; i < 4; i++) begin
            b = w[8*i +: 8];
            if (b[7:6] == 2'b00) b = 8'h00;
            else if (b[5:4] == 2'b01) b = {4'h0, b[3:0]};
            w[8*i +: 8] = b;
        end
        return w;
    endfunction

    function automatic attr_word_t make_lo(input int addr, input bit mode, input int x);
        attr_word_t a;
        a = '0;
        a[11:0]  = 12'(addr);
        a[15]    = mode;
        a[25:16] = 10'(x);
        return a;
    endfunction

    function automatic attr_word_t make_hi(input int y, input bit hf, input bit vf,
                                           input int z, input int pal, input int w, input int h);
        attr_word_t a;
        a = '0;
        a[9:0]   = 10'(y);
        a[16]    = hf;
        a[17]    = vf;
        a[19:18] = 2'(z);
        a[27:24] = 4'(pal);
        a[29:28] = 2'(w);
        a[31:30] = 2'(h);
        return a;
    endfunction

    // Expected line buffer with sprites walked in index order
    function automatic void compute_expected(input line_idx_t line, input zdepth_t clear_z);
        attr_word_t hi, lo;
        logic [9:0] ydiff;
        int hlast, row, width, wpr_log, sidx, widx;
        bit mode;
        bus_data_t w;
        logic [7:0] b, raw, colour;
        logic [1:0] z;
        xpos_t pos;
        for (int i = 0; i < 1024; i++) exp_buf[i] = {clear_z, 8'h00};
        for (int s = 0; s < 128; s++) begin
            hi = attr_hi[s];
            lo = attr_lo[s];
            z = hi[19:18];
            hlast = (8 << hi[31:30]) - 1;
            ydiff = {1'b0, line} - hi[9:0];
            if (z == 2'd0 || int'(ydiff) > hlast) continue;
            row = hi[17] ? hlast - int'(ydiff) : int'(ydiff);
            width = 8 << hi[29:28];
            mode = lo[15];
            wpr_log = int'(hi[29:28]) + int'(mode);
            for (int x = 0; x < width; x++) begin
                sidx = hi[16] ? width - 1 - x : x;
                widx = mode ? sidx >> 2 : sidx >> 3;
                w = gfx_word(bus_addr_t'(int'(lo[11:0]) * 8 + (row << wpr_log) + widx));
                if (mode) begin
                    raw = w[8*(sidx % 4) +: 8];
                end else begin
                    b = w[8*((sidx / 2) % 4) +: 8];
                    raw = {4'h0, (sidx % 2 == 1) ? b[3:0] : b[7:4]};
                end
                colour = (raw != 0 && raw[7:4] == 0) ? {hi[27:24], raw[3:0]} : raw;
                pos = xpos_t'(int'(lo[25:16]) + x);
                if (raw != 0 && (z > exp_buf[pos][9:8] || exp_buf[pos][7:0] == 0))
                    exp_buf[pos] = {z, colour};
            end
        end
    endfunction

    task automatic clear_attrs();
        for (int i = 0; i < 128; i++) begin
            attr_lo[i] = '0;
            attr_hi[i] = '0;
        end
    endtask

    task automatic run_line(input line_idx_t line, input bit full,
                            input zdepth_t clear_z = 2'd0);
        for (int i = 0; i < 1024; i++) lb_mem[i] = {clear_z, 8'h00};
        @(posedge clk);
        line_idx <= line;
        line_render_start <= 1'b1;
        @(posedge clk);
        line_render_start <= 1'b0;
        @(negedge clk);
        while (since_start != RENDER_CYCLES) @(negedge clk);
        if (full) begin
            compute_expected(line, clear_z);
            compare_pending = 1'b1;
            wait (!compare_pending);
            @(negedge clk);
        end
    endtask

    //////////////////////////////////////////////////
    // Models
    //////////////////////////////////////////////////
    assign sprite_attr = sprite_idx[0] ? attr_hi[sprite_idx[7:1]] : attr_lo[sprite_idx[7:1]];

    always @(posedge clk) begin
        if (linebuf_wren) lb_mem[linebuf_wridx] <= linebuf_wrdata;
        linebuf_rddata <= lb_mem[linebuf_rdidx];
    end

    // Acknowledge after 0 to 3 cycles
    always @(posedge clk) begin
        if (bus_ack) begin
            bus_ack <= 1'b0;
            lfsr = lfsr_next(lfsr);
            wait_cnt[0] = lfsr[0];
            lfsr = lfsr_next(lfsr);
            wait_cnt[1] = lfsr[0];
        end else if (bus_strobe) begin
            if (wait_cnt == 2'd0) begin
                bus_ack <= 1'b1;
                bus_rddata <= gfx_word(bus_addr);
            end else begin
                wait_cnt = wait_cnt - 2'd1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Checks and timeout
    //////////////////////////////////////////////////
    always @(posedge clk or posedge rst) begin
        if (rst) since_start <= RENDER_CYCLES;
        else if (line_render_start) since_start <= 0;
        else if (since_start < RENDER_CYCLES) since_start <= since_start + 1;
    end

    always @(posedge clk) begin
        assert (!linebuf_wren || since_start < RENDER_CYCLES) else begin
            $display("Line buffer write at %0t after the render budget expired", $time);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
        if (compare_pending) begin
            for (int i = 0; i < 1024; i++) begin
                assert (lb_mem[i] == exp_buf[i]) else begin
                    $display("Mismatch at %0t: linebuf[%0d] got %h expected %h",
                             $time, i, lb_mem[i], exp_buf[i]);
                    $display("SIMULATION FAILED");
                    $fatal(1);
                end
            end
            compare_pending = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout after %0d cycles", cycles);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    initial begin
        clk = 1'b0;
        rst = 1'b1;
        line_idx = '0;
        line_render_start = 1'b0;
        bus_ack = 1'b0;
        bus_rddata = '0;
        linebuf_rddata = '0;
        lfsr = 16'd59888;
        wait_cnt = 2'd1;
        cycles = 0;
        compare_pending = 1'b0;
        clear_attrs();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        // 4 bpp, 8 pixels, palette 5
        attr_lo[0] = make_lo(3, 0, 10);
        attr_hi[0] = make_hi(18, 0, 0, 1, 5, 0, 0);
        run_line(20, 1);

        // 8 bpp widths 16 and 32 with palette 6 on the narrow one
        clear_attrs();
        attr_lo[2] = make_lo(20, 1, 100);
        attr_hi[2] = make_hi(25, 0, 0, 2, 6, 1, 1);
        attr_lo[9] = make_lo(40, 1, 300);
        attr_hi[9] = make_hi(0, 0, 0, 1, 0, 2, 2);
        run_line(30, 1);

        // Flips
        clear_attrs();
        attr_lo[1] = make_lo(50, 0, 40);
        attr_hi[1] = make_hi(30, 1, 0, 1, 3, 1, 1);
        attr_lo[5] = make_lo(60, 1, 200);
        attr_hi[5] = make_hi(30, 0, 1, 2, 0, 1, 1);
        attr_lo[7] = make_lo(70, 1, 500);
        attr_hi[7] = make_hi(35, 1, 1, 3, 0, 2, 1);
        run_line(40, 1);

        // Overlap under z priority on empty entries that still carry z 3
        clear_attrs();
        attr_lo[3] = make_lo(80, 1, 60);
        attr_hi[3] = make_hi(10, 0, 0, 1, 0, 2, 1);
        attr_lo[4] = make_lo(90, 1, 70);
        attr_hi[4] = make_hi(10, 0, 0, 3, 0, 1, 1);
        attr_lo[6] = make_lo(100, 0, 64);
        attr_hi[6] = make_hi(12, 1, 0, 2, 9, 1, 0);
        run_line(15, 1, 2'd3);

        // Disabled and off-line sprites
        clear_attrs();
        attr_lo[0] = make_lo(5, 1, 20);
        attr_hi[0] = make_hi(50, 0, 0, 0, 0, 2, 2);
        attr_lo[1] = make_lo(6, 1, 80);
        attr_hi[1] = make_hi(100, 0, 0, 3, 0, 2, 0);
        run_line(55, 1);

        // Budget overflow, then a normal line
        clear_attrs();
        for (int i = 0; i < 40; i++) begin
            attr_lo[i] = make_lo(i * 16, 1, i * 16);
            attr_hi[i] = make_hi(60, i % 2, 0, 1 + i % 3, 0, 3, 0);
        end
        run_line(62, 0);
        clear_attrs();
        attr_lo[8] = make_lo(11, 0, 900);
        attr_hi[8] = make_hi(60, 0, 1, 2, 7, 1, 0);
        run_line(63, 1);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== vlog.f ====
common/sprite_pkg.sv
common/render_job_if.sv
rtl/sprite_search.sv
line_render/line_renderer.sv
line_render/pixel_merge.sv
rtl/sprite_renderer.sv
tb/sprite_renderer_checker.sv
tb/tb_sprite_renderer.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_sprite_renderer
FILELIST = vlog.f
OBJDIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out=$$(./$(OBJDIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
